// ==== penalty_pkg.sv ====
// penalty shoot-out match package
// match states, goal zones, cursor and round report types,
// match constants and the zone helpers used by both round blocks

package penalty_pkg;

    typedef enum logic [1:0] {
        START,
        SHOOT,
        KEEP,
        RESULT
    } g_state;

    typedef enum logic [1:0] {
        ZONE_LEFT,
        ZONE_MID,
        ZONE_RIGHT,
        ZONE_OUT
    } shot_zone;

    typedef struct packed {
        logic [11:0] xpos;
        logic [11:0] ypos;
    } cursor_t;

    typedef struct packed {
        logic done;
        logic scored;
    } round_report_t;

    // goal geometry in screen pixels
    localparam logic [11:0] ZONE_EDGE_L = 12'd213;
    localparam logic [11:0] ZONE_EDGE_R = 12'd426;
    localparam logic [11:0] GOAL_BOTTOM = 12'd200;

    localparam logic [7:0] ROUND_TICKS     = 8'd64;
    localparam logic [2:0] ROUNDS_PER_SIDE = 3'd5;

    // zone under the cursor, anything below the goal is out
    function automatic shot_zone zone_of(input cursor_t pos);
        if (pos.ypos > GOAL_BOTTOM) begin
            return ZONE_OUT;
        end
        if (pos.xpos < ZONE_EDGE_L) begin
            return ZONE_LEFT;
        end
        if (pos.xpos < ZONE_EDGE_R) begin
            return ZONE_MID;
        end
        return ZONE_RIGHT;
    endfunction

    // left -> mid -> right -> left, i.e. one step of r mod 3
    function automatic shot_zone next_zone(input shot_zone zone);
        case (zone)
            ZONE_LEFT: return ZONE_MID;
            ZONE_MID:  return ZONE_RIGHT;
            default:   return ZONE_LEFT;
        endcase
    endfunction

endpackage

// ==== game_state_sel.sv ====
// match state machine
// start screen, alternating shooting and keeping rounds, result screen

`timescale 1ns/1ns

module game_state_sel (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       left_click,
    input  logic                       right_click,
    input  penalty_pkg::round_report_t report_sh,
    input  penalty_pkg::round_report_t report_gk,
    input  logic                       match_end,
    output penalty_pkg::g_state        game_state
);

    penalty_pkg::g_state state_nxt;

    // match_end arrives on the same edge that leaves the last round,
    // so the round states also watch it and drop into RESULT
    always_comb begin
        state_nxt = game_state;
        case (game_state)
            penalty_pkg::START: begin
                if (left_click) begin
                    state_nxt = penalty_pkg::SHOOT;
                end
            end
            penalty_pkg::SHOOT: begin
                if (match_end) begin
                    state_nxt = penalty_pkg::RESULT;
                end else if (report_sh.done) begin
                    state_nxt = penalty_pkg::KEEP;
                end
            end
            penalty_pkg::KEEP: begin
                if (match_end) begin
                    state_nxt = penalty_pkg::RESULT;
                end else if (report_gk.done) begin
                    state_nxt = penalty_pkg::SHOOT;
                end
            end
            penalty_pkg::RESULT: begin
                if (right_click) begin
                    state_nxt = penalty_pkg::START;
                end
            end
            default: begin
                state_nxt = penalty_pkg::START;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            game_state <= penalty_pkg::START;
        end else begin
            game_state <= state_nxt;
        end
    end

    // only one round block may finish a round at a time
    a_single_report: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(report_sh.done && report_gk.done)
    ) else $error("shot and keeper reports raised together");

endmodule

// ==== round_timer.sv ====
// aiming window countdown
// reloads on round entry and on every report, pulses timeout at zero

`timescale 1ns/1ns

module round_timer (
    input  logic                clk,
    input  logic                arst_n,
    input  penalty_pkg::g_state game_state,
    input  logic                round_done,
    output logic                timeout
);

    penalty_pkg::g_state prev_state;
    logic [7:0]          ticks;
    logic                in_play;
    logic                load;

    assign in_play = (game_state == penalty_pkg::SHOOT) || (game_state == penalty_pkg::KEEP);

    // entry into a round is seen as a state change while in play
    assign load = round_done || (in_play && (game_state != prev_state));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev_state <= penalty_pkg::START;
            ticks      <= '0;
            timeout    <= 1'b0;
        end else begin
            prev_state <= game_state;
            // fires as the count reaches zero, held count then stays at zero
            timeout    <= in_play && !load && (ticks == 8'd1);
            if (load) begin
                ticks <= penalty_pkg::ROUND_TICKS;
            end else if (in_play && (ticks != '0)) begin
                ticks <= ticks - 8'd1;
            end
        end
    end

    a_timeout_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        timeout |=> !timeout
    ) else $error("timeout longer than one cycle");

endmodule

// ==== shoot_control.sv ====
// shooting round judge
// compares the player's shot zone with the computer keeper's dive

`timescale 1ns/1ns

module shoot_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       left_click,
    input  penalty_pkg::cursor_t       cursor,
    input  penalty_pkg::g_state        game_state,
    input  logic                       timeout,
    output penalty_pkg::round_report_t report
);

    penalty_pkg::shot_zone aim_zone;
    penalty_pkg::shot_zone keeper_zone;
    logic                  aiming;

    assign aim_zone = penalty_pkg::zone_of(cursor);

    // a round takes one decision, the cycle of the report is closed
    assign aiming = (game_state == penalty_pkg::SHOOT) && !report.done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            report      <= '0;
            keeper_zone <= penalty_pkg::ZONE_LEFT;
        end else begin
            report.done   <= 1'b0;
            report.scored <= 1'b0;

            if (aiming && left_click) begin
                report.done   <= 1'b1;
                report.scored <= (aim_zone != penalty_pkg::ZONE_OUT) &&
                                 (aim_zone != keeper_zone);
            end else if (aiming && timeout) begin
                // no shot taken, no goal
                report.done <= 1'b1;
            end

            // keeper dive follows round index mod 3
            if (game_state == penalty_pkg::START) begin
                keeper_zone <= penalty_pkg::ZONE_LEFT;
            end else if (report.done) begin
                keeper_zone <= penalty_pkg::next_zone(keeper_zone);
            end
        end
    end

endmodule

// ==== gloves_control.sv ====
// keeping round judge
// compares the player's glove zone with the computer's shot

`timescale 1ns/1ns

module gloves_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       left_click,
    input  penalty_pkg::cursor_t       cursor,
    input  penalty_pkg::g_state        game_state,
    input  logic                       timeout,
    output penalty_pkg::round_report_t report
);

    penalty_pkg::shot_zone glove_zone;
    penalty_pkg::shot_zone enemy_zone;
    logic                  guarding;

    assign glove_zone = penalty_pkg::zone_of(cursor);

    assign guarding = (game_state == penalty_pkg::KEEP) && !report.done;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            report     <= '0;
            enemy_zone <= penalty_pkg::ZONE_MID;
        end else begin
            report.done   <= 1'b0;
            report.scored <= 1'b0;

            if (guarding && left_click) begin
                // save only when the glove sits in the shot zone
                report.done   <= 1'b1;
                report.scored <= (glove_zone != enemy_zone);
            end else if (guarding && timeout) begin
                report.done   <= 1'b1;
                report.scored <= 1'b1;
            end

            // computer shot is (r+1) mod 3, so round 0 aims mid
            if (game_state == penalty_pkg::START) begin
                enemy_zone <= penalty_pkg::ZONE_MID;
            end else if (report.done) begin
                enemy_zone <= penalty_pkg::next_zone(enemy_zone);
            end
        end
    end

endmodule

// ==== score_control.sv ====
// match score keeper
// counts goals and rounds per side, flags match end and the winner

`timescale 1ns/1ns

module score_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  penalty_pkg::g_state        game_state,
    input  penalty_pkg::round_report_t report_sh,
    input  penalty_pkg::round_report_t report_gk,
    output logic [2:0]                 score_player,
    output logic [2:0]                 score_enemy,
    output logic                       match_end,
    output logic                       match_result
);

    logic [2:0] rounds_sh;
    logic [2:0] rounds_gk;
    logic [2:0] rounds_sh_nxt;
    logic [2:0] rounds_gk_nxt;
    logic [2:0] score_player_nxt;
    logic [2:0] score_enemy_nxt;

    // a side stops counting once its rounds are used up
    always_comb begin
        rounds_sh_nxt    = rounds_sh;
        rounds_gk_nxt    = rounds_gk;
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;
        if (report_sh.done && (rounds_sh < penalty_pkg::ROUNDS_PER_SIDE)) begin
            rounds_sh_nxt = rounds_sh + 3'd1;
            if (report_sh.scored) begin
                score_player_nxt = score_player + 3'd1;
            end
        end
        if (report_gk.done && (rounds_gk < penalty_pkg::ROUNDS_PER_SIDE)) begin
            rounds_gk_nxt = rounds_gk + 3'd1;
            if (report_gk.scored) begin
                score_enemy_nxt = score_enemy + 3'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rounds_sh    <= '0;
            rounds_gk    <= '0;
            score_player <= '0;
            score_enemy  <= '0;
            match_end    <= 1'b0;
        end else if (game_state == penalty_pkg::START) begin
            rounds_sh    <= '0;
            rounds_gk    <= '0;
            score_player <= '0;
            score_enemy  <= '0;
            match_end    <= 1'b0;
        end else begin
            rounds_sh    <= rounds_sh_nxt;
            rounds_gk    <= rounds_gk_nxt;
            score_player <= score_player_nxt;
            score_enemy  <= score_enemy_nxt;
            match_end    <= (rounds_sh_nxt == penalty_pkg::ROUNDS_PER_SIDE) &&
                            (rounds_gk_nxt == penalty_pkg::ROUNDS_PER_SIDE);
        end
    end

    // result is declared only at match end, a draw counts as a loss
    assign match_result = match_end && (score_player > score_enemy);

    a_score_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (score_player <= penalty_pkg::ROUNDS_PER_SIDE) &&
        (score_enemy <= penalty_pkg::ROUNDS_PER_SIDE)
    ) else $error("score above rounds per side");

endmodule

// ==== penalty_core.sv ====
// penalty shoot-out match logic top
// state machine, round timer, shot and keeper judges and score keeper

`timescale 1ns/1ns

module penalty_core (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 left_click,
    input  logic                 right_click,
    input  penalty_pkg::cursor_t cursor,
    output penalty_pkg::g_state  game_state,
    output logic [2:0]           score_player,
    output logic [2:0]           score_enemy,
    output logic                 match_end,
    output logic                 match_result
);

    penalty_pkg::round_report_t report_sh;
    penalty_pkg::round_report_t report_gk;
    logic                       timeout;
    logic                       round_done;

    assign round_done = report_sh.done | report_gk.done;

    game_state_sel u_game_state_sel (
        .clk, .arst_n, .left_click, .right_click,
        .report_sh, .report_gk, .match_end, .game_state
    );

    round_timer u_round_timer (.clk, .arst_n, .game_state, .round_done, .timeout);

    shoot_control u_shoot_control (
        .clk, .arst_n, .left_click, .cursor, .game_state, .timeout, .report(report_sh)
    );

    gloves_control u_gloves_control (
        .clk, .arst_n, .left_click, .cursor, .game_state, .timeout, .report(report_gk)
    );

    score_control u_score_control (
        .clk, .arst_n, .game_state, .report_sh, .report_gk,
        .score_player, .score_enemy, .match_end, .match_result
    );

endmodule

// ==== tb_penalty_core.sv ====
// testbench for the penalty shoot-out match logic
// replays a cycle trace of cursor and clicks, checks state, scores and result

`timescale 1ns/1ns

module tb_penalty_core;

    localparam int MAX_STEPS    = 64;
    localparam int TRACE_CYCLES = 159;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 50;

    // one trace line, held for repeat_cnt cycles
    typedef struct packed {
        logic [7:0]           repeat_cnt;
        penalty_pkg::cursor_t pos;
        logic                 left;
        logic                 right;
        logic [1:0]           state;
        logic [2:0]           score_p;
        logic [2:0]           score_e;
        logic                 ended;
        logic                 result;
    } step_t;

    logic                 clk;
    logic                 arst_n;
    logic                 left_click;
    logic                 right_click;
    penalty_pkg::cursor_t cursor;
    penalty_pkg::g_state  game_state;
    logic [2:0]           score_player;
    logic [2:0]           score_enemy;
    logic                 match_end;
    logic                 match_result;

    step_t steps [MAX_STEPS];
    int    n_steps      = 0;
    int    trace_cycles = 0;
    int    errors       = 0;
    int    cycle_count  = 0;
    int    cycle_limit  = RESET_CYCLES + MARGIN;

    penalty_core i_penalty_core (
        .clk, .arst_n, .left_click, .right_click, .cursor,
        .game_state, .score_player, .score_enemy, .match_end, .match_result
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic finish_run();
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAILED at %0t ns: %s expected %0d actual %0d", $time, name, expected, actual);
        errors++;
    endtask

    task automatic load_trace();
        int    fd;
        int    cnt;
        int    f [10];
        string line;
        fd = $fopen("penalty_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file penalty_trace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (line.getc(0) == "#") begin
                continue;
            end
            if (cnt == 10 && n_steps < MAX_STEPS) begin
                steps[n_steps].repeat_cnt = 8'(f[0]);
                steps[n_steps].pos.xpos   = 12'(f[1]);
                steps[n_steps].pos.ypos   = 12'(f[2]);
                steps[n_steps].left       = (f[3] != 0);
                steps[n_steps].right      = (f[4] != 0);
                steps[n_steps].state      = 2'(f[5]);
                steps[n_steps].score_p    = 3'(f[6]);
                steps[n_steps].score_e    = 3'(f[7]);
                steps[n_steps].ended      = (f[8] != 0);
                steps[n_steps].result     = (f[9] != 0);
                trace_cycles += f[0];
                n_steps++;
            end else if (cnt > 0) begin
                $display("trace line %0d is malformed or past the step limit", n_steps);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // inputs change 1 ns after the edge, outputs are checked 1 ns before the next
    task automatic run_step(input step_t st);
        for (int k = 0; k < int'(st.repeat_cnt); k++) begin
            @(posedge clk);
            #1;
            cursor      = st.pos;
            left_click  = st.left;
            right_click = st.right;
            #2;
            if (game_state != penalty_pkg::g_state'(st.state)) begin
                report_mismatch("game_state", int'(st.state), int'(game_state));
            end
            if (score_player != st.score_p) begin
                report_mismatch("score_player", int'(st.score_p), int'(score_player));
            end
            if (score_enemy != st.score_e) begin
                report_mismatch("score_enemy", int'(st.score_e), int'(score_enemy));
            end
            if (match_end != st.ended) begin
                report_mismatch("match_end", int'(st.ended), int'(match_end));
            end
            if (match_result != st.result) begin
                report_mismatch("match_result", int'(st.result), int'(match_result));
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("run went past the limit of %0d cycles", cycle_limit);
            errors++;
            finish_run();
        end
    end

    initial begin
        arst_n      = 1'b0;
        left_click  = 1'b0;
        right_click = 1'b0;
        cursor      = '0;
        load_trace();
        if (trace_cycles < TRACE_CYCLES) begin
            $display("trace holds %0d cycles, fewer than the %0d expected",
                     trace_cycles, TRACE_CYCLES);
            errors++;
        end
        cycle_limit = trace_cycles + RESET_CYCLES + MARGIN;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            run_step(steps[i]);
        end
        finish_run();
    end

endmodule

// ==== penalty_trace.txt ====
# repeat xpos ypos left right state score_player score_enemy match_end match_result
# state 0 start 1 shoot 2 keep 3 result, a line holds for repeat cycles
1 0 0 0 0 0 0 0 0 0
1 300 100 1 0 0 0 0 0 0
# shot mid against keeper left scores
1 300 100 1 0 1 0 0 0 0
1 0 0 0 0 1 0 0 0 0
# glove mid against shot mid saves
1 300 100 1 0 2 1 0 0 0
1 0 0 0 0 2 1 0 0 0
# shot mid against keeper mid is saved
1 300 100 1 0 1 1 0 0 0
1 0 0 0 0 1 1 0 0 0
# glove left against shot right concedes
1 100 100 1 0 2 1 0 0 0
1 0 0 0 0 2 1 0 0 0
# shot below the goal is out
1 300 300 1 0 1 1 1 0 0
1 0 0 0 0 1 1 1 0 0
# keeping round runs out, goal conceded
67 0 0 0 0 2 1 1 0 0
# shooting round runs out, no goal
67 0 0 0 0 1 1 2 0 0
# glove right against shot mid concedes
1 500 100 1 0 2 1 2 0 0
1 0 0 0 0 2 1 2 0 0
# shot left against keeper mid scores
1 100 100 1 0 1 1 3 0 0
1 0 0 0 0 1 1 3 0 0
# glove right against shot right saves, last round
1 500 100 1 0 2 2 3 0 0
1 0 0 0 0 2 2 3 0 0
1 0 0 0 0 1 2 3 1 0
1 0 0 0 0 3 2 3 1 0
1 0 0 0 1 3 2 3 1 0
1 0 0 0 0 0 2 3 1 0
1 0 0 0 0 0 0 0 0 0
1 0 0 1 0 0 0 0 0 0
1 0 0 0 0 1 0 0 0 0

// ==== penalty_core.f ====
penalty_pkg.sv
game_state_sel.sv
round_timer.sv
shoot_control.sv
gloves_control.sv
score_control.sv
penalty_core.sv
tb_penalty_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the penalty core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_penalty_core -f penalty_core.f
out=$(./obj_dir/Vtb_penalty_core)
echo "$out"
echo "$out" | grep -q "TESTS PASSED"
